//--- Makefile
TOOL   = verilator
FLAGS  = --binary --timing --assert -j 0
TOP    = cacheTb
FLIST  = flist.f
OBJDIR = obj_dir
LOG    = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FLIST)

run: build
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

lint:
	$(TOOL) --lint-only -Wall --timing --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- flist.f
hdl/cachePkg.sv
hdl/cacheLookup.sv
hdl/lineStore.sv
hdl/lineService.sv
hdl/dataCacheTop.sv
verif/arbiterMemModel.sv
verif/cacheTb.sv

//--- hdl/cacheLookup.sv
/* Lookup stage of the data cache
   Core request register, tag array, valid bits and tag compare */
`timescale 1ns/1ps

module cacheLookup (
   input  logic              rwArbiterCacheBus,
   input  logic              arstN,
   input  logic              reqCyc,
   input  cachePkg::coreReqT coreReq,
   output logic              reqAck,
   output logic              lookupValid,
   input  logic              lookupReady,
   output cachePkg::lookupT  lookup
);
   import cachePkg::*;

   // Stage occupancy and pipeline phases
   logic    stageBusy;
   logic    tagReadPending;
   logic    comparePending;
   logic    accept;
   logic    handoff;

   // Held request and its fields
   coreReqT stageReq;
   tagT     reqLineTag;
   indexT   reqIndex;

   // Tag state per line
   tagT                  tagArray [lineCount];
   logic [lineCount-1:0] lineValid;
   tagT                  storedTag;
   logic                 storedValid;
   logic                 hitReg;

   assign reqLineTag = tagOf(stageReq.addr);
   assign reqIndex   = indexOf(stageReq.addr);

   // New request only into an empty stage
   assign accept  = reqCyc && !stageBusy;
   assign handoff = lookupValid && lookupReady;

   always_ff @(posedge rwArbiterCacheBus or negedge arstN) begin
      if (!arstN) begin
         stageBusy      <= 1'b0;
         tagReadPending <= 1'b0;
         comparePending <= 1'b0;
         lookupValid    <= 1'b0;
         reqAck         <= 1'b0;
         lineValid      <= '0;
      end else begin
         // One-cycle acknowledge pulse
         reqAck         <= accept;
         tagReadPending <= accept;
         comparePending <= tagReadPending;

         if (accept) begin
            stageBusy <= 1'b1;
         end else if (handoff) begin
            stageBusy <= 1'b0;
         end

         if (comparePending) begin
            lookupValid <= 1'b1;
         end else if (handoff) begin
            lookupValid <= 1'b0;
         end

         // Line claimed as soon as the miss leaves
         if (handoff && !hitReg) begin
            lineValid[reqIndex] <= 1'b1;
         end
      end
   end

   always_ff @(posedge rwArbiterCacheBus) begin
      if (accept) begin
         stageReq <= coreReq;
      end
      // Registered tag read
      if (tagReadPending) begin
         storedTag   <= tagArray[reqIndex];
         storedValid <= lineValid[reqIndex];
      end
      if (comparePending) begin
         hitReg <= storedValid && (storedTag == reqLineTag);
      end
      // Later lookups see the new owner
      if (handoff && !hitReg) begin
         tagArray[reqIndex] <= reqLineTag;
      end
   end

   assign lookup = '{req: stageReq, hit: hitReg};

   // One-cycle acknowledge answers a pending core request
   assert property (@(posedge rwArbiterCacheBus) disable iff (!arstN)
      reqAck |-> $past(reqCyc) && !$past(reqAck));

   // Offered lookup waits unchanged for line service
   assert property (@(posedge rwArbiterCacheBus) disable iff (!arstN)
      lookupValid && !lookupReady |=> lookupValid && $stable(lookup));

endmodule

//--- hdl/cachePkg.sv
/* Shared definitions of the direct-mapped data cache
   Geometry constants, vector types, bus and stage structs,
   line service state encoding and address split helpers */
package cachePkg;

   // Geometry
   localparam int addrWidth    = 32;
   localparam int wordWidth    = 64;
   localparam int indexBits    = 6;
   localparam int offsetBits   = 3;
   localparam int byteBits     = 3;
   localparam int tagBits      = addrWidth - indexBits - offsetBits - byteBits;
   localparam int wordsPerLine = 1 << offsetBits;
   localparam int lineCount    = 1 << indexBits;
   localparam int reqTagWidth  = 8;

   typedef logic [addrWidth-1:0]   addrT;
   typedef logic [wordWidth-1:0]   wordT;
   typedef logic [tagBits-1:0]     tagT;
   typedef logic [indexBits-1:0]   indexT;
   typedef logic [offsetBits-1:0]  offsetT;
   typedef logic [reqTagWidth-1:0] reqTagT;
   // Whole line, word 0 in the low bits
   typedef logic [wordsPerLine-1:0][wordWidth-1:0] lineT;

   // Final beat of a burst
   localparam offsetT lastBeat = offsetT'(wordsPerLine - 1);

   typedef struct packed {
      addrT   addr;
      wordT   wdata;
      logic   isWrite;
      reqTagT reqTag;
   } coreReqT;

   typedef struct packed {
      wordT   data;
      reqTagT reqTag;
   } coreRespT;

   // Handed from lookup to line service
   typedef struct packed {
      coreReqT req;
      logic    hit;
   } lookupT;

   // One arbiter beat
   typedef struct packed {
      addrT addr;
      wordT data;
      logic isWrite;
   } memReqT;

   typedef struct packed {
      wordT data;
   } memRespT;

   typedef enum logic [2:0] {
      stIdle,
      stReadLine,
      stFillReq,
      stFillData,
      stMerge,
      stWriteReq,
      stWriteData,
      stRespond
   } serviceStateT;

   // Address fields
   function automatic tagT tagOf(input addrT addr);
      return addr[addrWidth-1 -: tagBits];
   endfunction

   function automatic indexT indexOf(input addrT addr);
      return addr[byteBits+offsetBits +: indexBits];
   endfunction

   function automatic offsetT offsetOf(input addrT addr);
      return addr[byteBits +: offsetBits];
   endfunction

   // Byte address of one word in a line
   function automatic addrT wordAddr(input tagT tag, input indexT index, input offsetT offset);
      return {tag, index, offset, {byteBits{1'b0}}};
   endfunction

endpackage

//--- hdl/dataCacheTop.sv
/* Top level of the data cache
   Lookup stage, line service stage and line store */
`timescale 1ns/1ps

module dataCacheTop (
   input  logic               rwArbiterCacheBus,
   input  logic               arstN,
   // Core side
   input  logic               reqCyc,
   input  cachePkg::coreReqT  coreReq,
   output logic               reqAck,
   output logic               respCyc,
   output cachePkg::coreRespT coreResp,
   input  logic               respAck,
   // Arbiter side
   output logic               memReqCyc,
   output cachePkg::memReqT   memReq,
   input  logic               memReqAck,
   input  logic               memRespCyc,
   input  cachePkg::memRespT  memResp,
   output logic               memRespAck
);
   import cachePkg::*;

   // Stage handoff
   logic   lookupValid;
   logic   lookupReady;
   lookupT lookup;

   // Line store ports
   indexT                   readIndex;
   indexT                   writeIndex;
   lineT                    readLine;
   lineT                    writeLine;
   logic [wordsPerLine-1:0] wordWrite;

   cacheLookup lookup0 (
      .rwArbiterCacheBus (rwArbiterCacheBus),
      .arstN             (arstN),
      .reqCyc            (reqCyc),
      .coreReq           (coreReq),
      .reqAck            (reqAck),
      .lookupValid       (lookupValid),
      .lookupReady       (lookupReady),
      .lookup            (lookup)
   );

   lineStore store0 (
      .rwArbiterCacheBus (rwArbiterCacheBus),
      .readIndex         (readIndex),
      .readLine          (readLine),
      .writeIndex        (writeIndex),
      .writeLine         (writeLine),
      .wordWrite         (wordWrite)
   );

   lineService service0 (
      .rwArbiterCacheBus (rwArbiterCacheBus),
      .arstN             (arstN),
      .lookupValid       (lookupValid),
      .lookup            (lookup),
      .lookupReady       (lookupReady),
      .readIndex         (readIndex),
      .writeIndex        (writeIndex),
      .readLine          (readLine),
      .writeLine         (writeLine),
      .wordWrite         (wordWrite),
      .memReqCyc         (memReqCyc),
      .memReq            (memReq),
      .memReqAck         (memReqAck),
      .memRespCyc        (memRespCyc),
      .memResp           (memResp),
      .memRespAck        (memRespAck),
      .respCyc           (respCyc),
      .coreResp          (coreResp),
      .respAck           (respAck)
   );

endmodule

//--- hdl/lineService.sv
/* Line service stage of the data cache
   Hit reads, line fills, write merge, write-through bursts
   and core responses */
`timescale 1ns/1ps

module lineService (
   input  logic                              rwArbiterCacheBus,
   input  logic                              arstN,
   input  logic                              lookupValid,
   input  cachePkg::lookupT                  lookup,
   output logic                              lookupReady,
   output cachePkg::indexT                   readIndex,
   output cachePkg::indexT                   writeIndex,
   input  cachePkg::lineT                    readLine,
   output cachePkg::lineT                    writeLine,
   output logic [cachePkg::wordsPerLine-1:0] wordWrite,
   output logic                              memReqCyc,
   output cachePkg::memReqT                  memReq,
   input  logic                              memReqAck,
   input  logic                              memRespCyc,
   input  cachePkg::memRespT                 memResp,
   output logic                              memRespAck,
   output logic                              respCyc,
   output cachePkg::coreRespT                coreResp,
   input  logic                              respAck
);
   import cachePkg::*;

   serviceStateT state;
   lookupT       cur;
   lineT         lineBuf;
   lineT         mergedLine;
   offsetT       beatCnt;
   // Set while the store read is in flight
   logic         readWait;
   tagT          curTag;
   indexT        curIndex;
   offsetT       curOffset;

   assign curTag    = tagOf(cur.req.addr);
   assign curIndex  = indexOf(cur.req.addr);
   assign curOffset = offsetOf(cur.req.addr);

   assign lookupReady = (state == stIdle);
   assign readIndex   = curIndex;
   assign writeIndex  = curIndex;
   // Fill beats taken in the cycle they arrive
   assign memRespAck  = (state == stFillData) && memRespCyc;

   // Write word dropped into the buffered line
   always_comb begin
      mergedLine = lineBuf;
      if (cur.req.isWrite) begin
         mergedLine[curOffset] = cur.req.wdata;
      end
   end

   // Store update in merge; a hit changes one word, a fill the whole line
   assign writeLine = mergedLine;
   always_comb begin
      wordWrite = '0;
      if (state == stMerge) begin
         if (cur.hit) begin
            wordWrite[curOffset] = 1'b1;
         end else begin
            wordWrite = '1;
         end
      end
   end

   // Fill request uses beat 0, i.e. the line-aligned address
   always_comb begin
      memReq.addr    = wordAddr(curTag, curIndex, beatCnt);
      memReq.isWrite = (state == stWriteReq);
      memReq.data    = (state == stWriteReq) ? lineBuf[beatCnt] : '0;
   end

   always_ff @(posedge rwArbiterCacheBus or negedge arstN) begin
      if (!arstN) begin
         state     <= stIdle;
         memReqCyc <= 1'b0;
         respCyc   <= 1'b0;
         readWait  <= 1'b0;
         beatCnt   <= '0;
      end else begin
         case (state)
            stIdle: begin
               if (lookupValid) begin
                  beatCnt <= '0;
                  if (lookup.hit) begin
                     state    <= stReadLine;
                     readWait <= 1'b1;
                  end else begin
                     state     <= stFillReq;
                     memReqCyc <= 1'b1;
                  end
               end
            end
            stReadLine: begin
               readWait <= 1'b0;
               if (!readWait) begin
                  if (cur.req.isWrite) begin
                     state <= stMerge;
                  end else begin
                     state   <= stRespond;
                     respCyc <= 1'b1;
                  end
               end
            end
            stFillReq: begin
               if (memReqAck) begin
                  memReqCyc <= 1'b0;
                  state     <= stFillData;
               end
            end
            stFillData: begin
               // Counter wraps to 0 for the write burst
               if (memRespCyc) begin
                  beatCnt <= beatCnt + 1'b1;
                  if (beatCnt == lastBeat) begin
                     state <= stMerge;
                  end
               end
            end
            stMerge: begin
               if (cur.req.isWrite) begin
                  state     <= stWriteReq;
                  memReqCyc <= 1'b1;
               end else begin
                  state   <= stRespond;
                  respCyc <= 1'b1;
               end
            end
            stWriteReq: begin
               if (memReqAck) begin
                  memReqCyc <= 1'b0;
                  state     <= stWriteData;
               end
            end
            stWriteData: begin
               // Gap cycle between write beats
               if (beatCnt == lastBeat) begin
                  state   <= stRespond;
                  respCyc <= 1'b1;
               end else begin
                  beatCnt   <= beatCnt + 1'b1;
                  memReqCyc <= 1'b1;
                  state     <= stWriteReq;
               end
            end
            stRespond: begin
               if (respAck) begin
                  respCyc <= 1'b0;
                  state   <= stIdle;
               end
            end
            default: state <= stIdle;
         endcase
      end
   end

   // Request, line buffer and response payload
   always_ff @(posedge rwArbiterCacheBus) begin
      case (state)
         stIdle: begin
            if (lookupValid) begin
               cur <= lookup;
            end
         end
         stReadLine: begin
            if (!readWait) begin
               lineBuf  <= readLine;
               coreResp <= '{data: readLine[curOffset], reqTag: cur.req.reqTag};
            end
         end
         stFillData: begin
            if (memRespCyc) begin
               lineBuf[beatCnt] <= memResp.data;
            end
         end
         stMerge: begin
            // Write response carries the written word
            lineBuf  <= mergedLine;
            coreResp <= '{data: mergedLine[curOffset], reqTag: cur.req.reqTag};
         end
         default: ;
      endcase
   end

   // Arbiter beat held until taken
   assert property (@(posedge rwArbiterCacheBus) disable iff (!arstN)
      memReqCyc && !memReqAck |=> memReqCyc && $stable(memReq));

endmodule

//--- hdl/lineStore.sv
/* Line data memory of the data cache
   Registered read port, write port with per-word enables */
`timescale 1ns/1ps

module lineStore (
   input  logic                              rwArbiterCacheBus,
   input  cachePkg::indexT                   readIndex,
   output cachePkg::lineT                    readLine,
   input  cachePkg::indexT                   writeIndex,
   input  cachePkg::lineT                    writeLine,
   input  logic [cachePkg::wordsPerLine-1:0] wordWrite
);
   import cachePkg::*;

   // One entry per line, contents trusted only under a valid bit
   lineT lineMem [lineCount];

   // Word-granular write
   always_ff @(posedge rwArbiterCacheBus) begin
      for (int w = 0; w < wordsPerLine; w++) begin
         if (wordWrite[w]) begin
            lineMem[writeIndex][w] <= writeLine[w];
         end
      end
   end

   // Read data one cycle after the index
   // Same-cycle write to the read index returns the old line
   always_ff @(posedge rwArbiterCacheBus) begin
      readLine <= lineMem[readIndex];
   end

endmodule

//--- verif/arbiterMemModel.sv
/* Testbench memory behind the arbiter port
   Fill bursts from a pattern or written words, write beat capture,
   random acknowledge delay from its own LCG */
`timescale 1ns/1ps

module arbiterMemModel (
   input  logic              rwArbiterCacheBus,
   input  logic              arstN,
   input  logic              memReqCyc,
   input  cachePkg::memReqT  memReq,
   output logic              memReqAck,
   output logic              memRespCyc,
   output cachePkg::memRespT memResp,
   input  logic              memRespAck
);
   import cachePkg::*;

   // Written words by byte address
   wordT        memWords [addrT];
   logic [31:0] lcgState;
   memReqT      beat;
   int          delay;

   function automatic logic [31:0] nextRand();
      lcgState = lcgState * 32'd1664525 + 32'd1013904223;
      return lcgState;
   endfunction

   // Untouched words follow a pattern over the whole address
   function automatic wordT peekWord(input addrT addr);
      if (memWords.exists(addr)) begin
         return memWords[addr];
      end
      return {~addr, addr};
   endfunction

   initial begin
      lcgState   = 32'h5d2e_31c4;
      memReqAck  = 1'b0;
      memRespCyc = 1'b0;
      memResp    = '0;
      forever begin
         @(negedge rwArbiterCacheBus);
         if (arstN && memReqCyc) begin
            // Beat stretched by 0 to 3 cycles
            delay = int'((nextRand() >> 16) % 4);
            repeat (delay) @(negedge rwArbiterCacheBus);
            @(posedge rwArbiterCacheBus);
            #2;
            memReqAck = 1'b1;
            // Beat as the DUT hands it over
            @(negedge rwArbiterCacheBus);
            beat = memReq;
            @(posedge rwArbiterCacheBus);
            #2;
            memReqAck = 1'b0;
            if (beat.isWrite) begin
               memWords[beat.addr] = beat.data;
            end else begin
               // Fill burst, next beat once the current one is taken
               for (int b = 0; b < wordsPerLine; b++) begin
                  memRespCyc   = 1'b1;
                  memResp.data = peekWord(beat.addr + addrT'(b * 8));
                  do begin
                     @(negedge rwArbiterCacheBus);
                  end while (!memRespAck);
                  @(posedge rwArbiterCacheBus);
                  #2;
               end
               memRespCyc = 1'b0;
            end
         end
      end
   end

endmodule

//--- verif/cacheTb.sv
/* Testbench top of the data cache
   Clock, reset, random core requests, reference memory and tag shadow,
   compare tasks, arbiter beat monitor, watchdog and summary */
`timescale 1ns/1ps

module cacheTb;
   import cachePkg::*;

   localparam int numReqs    = 400;
   localparam int hitLatency = 5;

   logic     rwArbiterCacheBus;
   logic     arstN;
   logic     reqCyc;
   coreReqT  coreReq;
   logic     reqAck;
   logic     respCyc;
   coreRespT coreResp;
   logic     respAck;
   logic     memReqCyc;
   memReqT   memReq;
   logic     memReqAck;
   logic     memRespCyc;
   memRespT  memResp;
   logic     memRespAck;

   // Reference memory and shadow of the tag state
   wordT                 refMem [addrT];
   tagT                  shadowTag [lineCount];
   logic [lineCount-1:0] shadowValid;

   // Beats seen on the arbiter port and beats predicted
   memReqT      beatLog [$];
   memReqT      expBeats [$];
   memReqT      lastReq;
   logic        reqWaiting = 1'b0;
   logic        respCycLast = 1'b0;
   logic [31:0] lcgState;
   int          respCount = 0;
   int          respErrors = 0;
   int          beatErrors = 0;
   int          latencyErrors = 0;
   int          wordErrors = 0;
   int          otherErrors = 0;

   dataCacheTop dut0 (.*);
   arbiterMemModel mem0 (.*);

   initial begin
      rwArbiterCacheBus = 1'b0;
      forever #10 rwArbiterCacheBus = ~rwArbiterCacheBus;
   end

   function automatic logic [31:0] nextRand();
      lcgState = lcgState * 32'd1664525 + 32'd1013904223;
      return lcgState;
   endfunction

   // Upper LCG bits only since the low ones repeat quickly
   function automatic logic [31:0] randBelow(input int n);
      return (nextRand() >> 16) % n;
   endfunction

   function automatic wordT fillPattern(input addrT a);
      return {~a, a};
   endfunction

   function automatic wordT refWord(input addrT a);
      if (refMem.exists(a)) begin
         return refMem[a];
      end
      return fillPattern(a);
   endfunction

   task automatic checkResp(input string name, input coreRespT got, input coreRespT exp);
      if (got !== exp) begin
         respErrors++;
         $display("Error at %0t: %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic checkMemBeat(input string name, input memReqT got, input memReqT exp);
      // Fill requests carry no data
      if (got.addr !== exp.addr || got.isWrite !== exp.isWrite ||
          (exp.isWrite && got.data !== exp.data)) begin
         beatErrors++;
         $display("Error at %0t: %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic checkLatency(input string name, input int got, input int exp);
      if (got != exp) begin
         latencyErrors++;
         $display("Error at %0t: %s got %0d expected %0d", $time, name, got, exp);
      end
   endtask

   task automatic checkWord(input string name, input wordT got, input wordT exp);
      if (got !== exp) begin
         wordErrors++;
         $display("Error at %0t: %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   // Mid-cycle view of the arbiter port and response handshakes
   always @(negedge rwArbiterCacheBus) begin
      if (arstN) begin
         if (reqWaiting) begin
            if (!memReqCyc) begin
               otherErrors++;
               $display("memReqCyc dropped at %0t before its acknowledge", $time);
            end
            checkMemBeat("memReq hold", memReq, lastReq);
         end
         if (memReqCyc && memReqAck) begin
            beatLog.push_back(memReq);
         end
         reqWaiting = memReqCyc && !memReqAck;
         lastReq    = memReq;
         // A response counts once, when respCyc rises
         if (respCyc && !respCycLast) begin
            respCount++;
         end
         respCycLast = respCyc;
      end
   end

   // One core request from prediction to response handshake
   task automatic runRequest(input int n);
      coreReqT  req;
      coreRespT expResp;
      memReqT   beat;
      tagT      tag;
      indexT    index;
      offsetT   offset;
      addrT     lineBase;
      addrT     a;
      logic     hit;
      int       lat;
      int       delay;

      // Three tags over four indices make conflicts frequent
      tag         = tagT'(32'h1a000 + randBelow(3));
      index       = indexT'(randBelow(4) * 17);
      offset      = offsetT'(randBelow(8));
      req.addr    = {tag, index, offset, 3'b000};
      req.isWrite = (randBelow(3) == 0);
      req.wdata   = {nextRand(), nextRand()};
      req.reqTag  = reqTagT'(n);
      lineBase    = {tag, index, 6'b000000};

      hit = shadowValid[index] && (shadowTag[index] == tag);
      expBeats.delete();
      if (!hit) begin
         beat.addr    = lineBase;
         beat.data    = '0;
         beat.isWrite = 1'b0;
         expBeats.push_back(beat);
      end
      if (req.isWrite) begin
         refMem[req.addr] = req.wdata;
         // Whole merged line goes out
         for (int w = 0; w < wordsPerLine; w++) begin
            a            = lineBase + addrT'(w * 8);
            beat.addr    = a;
            beat.data    = refWord(a);
            beat.isWrite = 1'b1;
            expBeats.push_back(beat);
         end
      end
      expResp.data     = req.isWrite ? req.wdata : refWord(req.addr);
      expResp.reqTag   = req.reqTag;
      shadowValid[index] = 1'b1;
      shadowTag[index]   = tag;

      @(posedge rwArbiterCacheBus);
      #2;
      reqCyc  = 1'b1;
      coreReq = req;
      do begin
         @(negedge rwArbiterCacheBus);
      end while (!reqAck);
      // Cycles from acknowledge to response
      lat = 0;
      do begin
         @(posedge rwArbiterCacheBus);
         #2;
         reqCyc = 1'b0;
         @(negedge rwArbiterCacheBus);
         lat++;
      end while (!respCyc);
      if (hit && !req.isWrite) begin
         checkLatency("read hit latency", lat, hitLatency);
      end
      checkResp("coreResp", coreResp, expResp);

      // Response must hold while respAck stays low
      delay = int'(randBelow(4));
      repeat (delay) begin
         @(posedge rwArbiterCacheBus);
         #2;
         @(negedge rwArbiterCacheBus);
         if (!respCyc) begin
            otherErrors++;
            $display("respCyc dropped at %0t before respAck", $time);
         end
         checkResp("coreResp hold", coreResp, expResp);
      end
      @(posedge rwArbiterCacheBus);
      #2;
      respAck = 1'b1;
      @(posedge rwArbiterCacheBus);
      #2;
      respAck = 1'b0;

      if (beatLog.size() != expBeats.size()) begin
         otherErrors++;
         $display("Request %0d saw %0d arbiter beats where %0d were due",
                  n, beatLog.size(), expBeats.size());
      end else begin
         foreach (expBeats[b]) begin
            checkMemBeat("memReq", beatLog[b], expBeats[b]);
         end
      end
      beatLog.delete();

      // Memory behind the arbiter after write-through
      if (req.isWrite) begin
         for (int w = 0; w < wordsPerLine; w++) begin
            a = lineBase + addrT'(w * 8);
            checkWord($sformatf("memory word %h", a), mem0.peekWord(a), refWord(a));
         end
      end
   endtask

   initial begin
      lcgState    = 32'hf880_a799;
      arstN       = 1'b0;
      reqCyc      = 1'b0;
      coreReq     = '0;
      respAck     = 1'b0;
      shadowValid = '0;
      repeat (10) @(posedge rwArbiterCacheBus);
      #2;
      arstN = 1'b1;
      @(negedge rwArbiterCacheBus);
      if (reqAck || respCyc || memReqCyc || memRespAck) begin
         otherErrors++;
         $display("Handshake outputs not idle after reset");
      end

      for (int n = 0; n < numReqs; n++) begin
         runRequest(n);
      end
      repeat (5) @(posedge rwArbiterCacheBus);
      if (respCount != numReqs) begin
         otherErrors++;
         $display("%0d responses completed for %0d requests", respCount, numReqs);
      end

      $display("Errors: resp %0d, beat %0d, latency %0d, memory %0d, other %0d",
               respErrors, beatErrors, latencyErrors, wordErrors, otherErrors);
      if (respErrors + beatErrors + latencyErrors + wordErrors + otherErrors == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

   // Bound of 200 cycles per request covers a miss with write-through
   initial begin
      repeat (numReqs * 200) @(posedge rwArbiterCacheBus);
      $display("Watchdog expired after %0d cycles with requests still open", numReqs * 200);
      $display("SIMULATION FAILED");
      $finish;
   end

endmodule
